//--- uopPkg.sv
package uopPkg;

    // Default number of micro-ops handled per cycle.
    parameter int DEF_WIDTH = 2;

    // Default number of queue entries, a power of two.
    parameter int DEF_QUEUE_DEPTH = 8;

    // Functional unit that executes a micro-op.
    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_BRANCH,
        FU_ILLEGAL
    } FuType;

    // Operation within the functional unit.
    typedef enum logic [4:0] {
        INT_ADD,
        INT_SUB,
        INT_AND,
        INT_OR,
        INT_XOR,
        INT_SLT,
        INT_SLTU,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_LUI,
        INT_AUIPC,
        LSU_LW,
        LSU_SW,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } OpCode;

    // One decoded micro-op.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        FuType       fu;
        OpCode       opcode;
        logic [4:0]  rs0;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        // Second operand comes from imm instead of rs1.
        logic        immB;
        logic [31:0] imm;
    } DUOp;

    // One fetched instruction word.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } FetchSlot;

endpackage

//--- InstrDecoder.sv
`timescale 1ns/1ps

module InstrDecoder #(
    parameter int WIDTH = uopPkg::DEF_WIDTH
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  logic            mispredict,
    input  uopPkg::FetchSlot fetch[WIDTH],
    output uopPkg::DUOp     decUOps[WIDTH]
);

    import uopPkg::*;

    function automatic DUOp decodeSlot(FetchSlot s);
        DUOp         u;
        logic [6:0]  major;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immBr;
        logic [31:0] immJ;
        logic [31:0] immU;

        major  = s.instr[6:0];
        funct3 = s.instr[14:12];
        funct7 = s.instr[31:25];
        immI   = {{20{s.instr[31]}}, s.instr[31:20]};
        immS   = {{20{s.instr[31]}}, s.instr[31:25], s.instr[11:7]};
        immBr  = {{19{s.instr[31]}}, s.instr[31], s.instr[7], s.instr[30:25],
                  s.instr[11:8], 1'b0};
        immJ   = {{11{s.instr[31]}}, s.instr[31], s.instr[19:12], s.instr[20],
                  s.instr[30:21], 1'b0};
        immU   = {s.instr[31:12], 12'b0};

        u        = '0;
        u.valid  = s.valid;
        u.pc     = s.pc;
        u.fu     = FU_INT;
        u.opcode = INT_ADD;
        u.rs0    = s.instr[19:15];
        u.rs1    = s.instr[24:20];
        u.rd     = s.instr[11:7];

        case (major)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: u.opcode = INT_ADD;
                    10'b0100000_000: u.opcode = INT_SUB;
                    10'b0000000_001: u.opcode = INT_SLL;
                    10'b0000000_010: u.opcode = INT_SLT;
                    10'b0000000_011: u.opcode = INT_SLTU;
                    10'b0000000_100: u.opcode = INT_XOR;
                    10'b0000000_101: u.opcode = INT_SRL;
                    10'b0100000_101: u.opcode = INT_SRA;
                    10'b0000000_110: u.opcode = INT_OR;
                    10'b0000000_111: u.opcode = INT_AND;
                    default:         u.fu = FU_ILLEGAL;
                endcase
            end
            7'b0010011: begin
                u.rs1  = '0;
                u.immB = 1'b1;
                u.imm  = immI;
                case (funct3)
                    3'b000: u.opcode = INT_ADD;
                    3'b010: u.opcode = INT_SLT;
                    3'b011: u.opcode = INT_SLTU;
                    3'b100: u.opcode = INT_XOR;
                    3'b110: u.opcode = INT_OR;
                    3'b111: u.opcode = INT_AND;
                    default: begin
                        // Shifts carry only the shift amount.
                        u.imm = {27'b0, s.instr[24:20]};
                        if (funct3 == 3'b001 && funct7 == 7'b0000000)
                            u.opcode = INT_SLL;
                        else if (funct3 == 3'b101 && funct7 == 7'b0000000)
                            u.opcode = INT_SRL;
                        else if (funct3 == 3'b101 && funct7 == 7'b0100000)
                            u.opcode = INT_SRA;
                        else
                            u.fu = FU_ILLEGAL;
                    end
                endcase
            end
            7'b0110111, 7'b0010111: begin
                u.opcode = (major == 7'b0110111) ? INT_LUI : INT_AUIPC;
                u.rs0    = '0;
                u.rs1    = '0;
                u.immB   = 1'b1;
                u.imm    = immU;
            end
            7'b0000011: begin
                u.fu     = (funct3 == 3'b010) ? FU_LSU : FU_ILLEGAL;
                u.opcode = LSU_LW;
                u.rs1    = '0;
                u.immB   = 1'b1;
                u.imm    = immI;
            end
            7'b0100011: begin
                // Address is rs0 plus imm, store data comes from rs1.
                u.fu     = (funct3 == 3'b010) ? FU_LSU : FU_ILLEGAL;
                u.opcode = LSU_SW;
                u.rd     = '0;
                u.immB   = 1'b1;
                u.imm    = immS;
            end
            7'b1100011: begin
                u.fu     = (funct3 == 3'b000 || funct3 == 3'b001) ? FU_BRANCH : FU_ILLEGAL;
                u.opcode = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
                u.rd     = '0;
                u.imm    = immBr;
            end
            7'b1101111: begin
                u.fu     = FU_BRANCH;
                u.opcode = BR_JAL;
                u.rs0    = '0;
                u.rs1    = '0;
                u.imm    = immJ;
            end
            default: u.fu = FU_ILLEGAL;
        endcase

        // Illegal ops keep only their place in the stream.
        if (u.fu == FU_ILLEGAL) begin
            u       = '0;
            u.valid = s.valid;
            u.pc    = s.pc;
            u.fu    = FU_ILLEGAL;
        end
        return u;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            for (int i = 0; i < WIDTH; i++) begin
                decUOps[i].valid <= 1'b0;
            end
        end else if (en) begin
            for (int i = 0; i < WIDTH; i++) begin
                decUOps[i] <= decodeSlot(fetch[i]);
            end
        end
    end

    for (genvar i = 0; i < WIDTH; i++) begin : gIllegalRd
        assert property (@(posedge clk) disable iff (rst)
            decUOps[i].valid && decUOps[i].fu == FU_ILLEGAL |-> decUOps[i].rd == '0);
    end

endmodule

//--- UOpFuse.sv
`timescale 1ns/1ps

module UOpFuse #(
    parameter int WIDTH = uopPkg::DEF_WIDTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  logic        mispredict,
    input  uopPkg::DUOp decUOps[WIDTH],
    output uopPkg::DUOp fusedUOps[WIDTH]
);

    import uopPkg::*;

    DUOp              held[WIDTH];
    DUOp              heldNext[WIDTH];
    DUOp              fusedNext[WIDTH];
    DUOp              window[WIDTH+1];
    logic [WIDTH:0]   kill;
    logic [WIDTH-1:0] mergeNext;
    logic [WIDTH-1:0] mergedMask;

    function automatic logic canFuse(DUOp a, DUOp b);
        return a.valid && b.valid &&
               a.fu == FU_INT && (a.opcode == INT_LUI || a.opcode == INT_AUIPC) &&
               b.fu == FU_INT && b.opcode == INT_ADD && b.immB &&
               b.rs0 == b.rd && a.rd == b.rd;
    endfunction

    always_comb begin
        logic lastFused;

        lastFused = 1'b0;
        kill      = '0;
        mergeNext = '0;

        // Held group plus slot 0 of the incoming group.
        for (int i = 0; i < WIDTH; i++) begin
            window[i] = held[i];
        end
        window[WIDTH] = decUOps[0];

        fusedNext = held;
        heldNext  = decUOps;

        for (int i = 0; i < WIDTH; i++) begin
            if (!lastFused && canFuse(window[i], window[i+1])) begin
                fusedNext[i].imm = {window[i].imm[31:12], 12'b0} +
                                   {{20{window[i+1].imm[11]}}, window[i+1].imm[11:0]};
                kill[i+1]    = 1'b1;
                mergeNext[i] = 1'b1;
                lastFused    = 1'b1;
            end else begin
                lastFused = 1'b0;
            end
        end

        // The absorbed ADDI may sit in the next group.
        for (int i = 0; i < WIDTH; i++) begin
            fusedNext[i].valid = fusedNext[i].valid && !kill[i];
        end
        heldNext[0].valid = decUOps[0].valid && !kill[WIDTH];
    end

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            for (int i = 0; i < WIDTH; i++) begin
                held[i].valid      <= 1'b0;
                fusedUOps[i].valid <= 1'b0;
            end
            mergedMask <= '0;
        end else if (en) begin
            held       <= heldNext;
            fusedUOps  <= fusedNext;
            mergedMask <= mergeNext;
        end
    end

    for (genvar i = 0; i < WIDTH - 1; i++) begin : gPairInGroup
        assert property (@(posedge clk) disable iff (rst)
            fusedUOps[i].valid && mergedMask[i] |-> !fusedUOps[i+1].valid);
    end

    // Partner of the last slot shows up as slot 0 of the next group.
    assert property (@(posedge clk) disable iff (rst)
        en && !mispredict && fusedUOps[WIDTH-1].valid && mergedMask[WIDTH-1]
        |=> !fusedUOps[0].valid);

endmodule

//--- UOpQueue.sv
`timescale 1ns/1ps

module UOpQueue #(
    parameter int WIDTH       = uopPkg::DEF_WIDTH,
    parameter int QUEUE_DEPTH = uopPkg::DEF_QUEUE_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  logic        mispredict,
    input  uopPkg::DUOp fusedUOps[WIDTH],
    output uopPkg::DUOp uops[WIDTH]
);

    import uopPkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    DUOp              mem[QUEUE_DEPTH];
    // One extra bit tells full from empty.
    logic [PTR_W:0]   wrPtr;
    logic [PTR_W:0]   rdPtr;
    logic [PTR_W:0]   fill;
    logic [PTR_W:0]   pushCnt;
    logic [PTR_W:0]   popCnt;
    logic [PTR_W:0]   wrOff[WIDTH];
    logic [PTR_W-1:0] wrAddr[WIDTH];
    logic [PTR_W-1:0] rdAddr[WIDTH];

    assign fill   = wrPtr - rdPtr;
    assign popCnt = (fill < (PTR_W+1)'(WIDTH)) ? fill : (PTR_W+1)'(WIDTH);

    // Valid inputs are packed in slot order.
    always_comb begin
        pushCnt = '0;
        for (int i = 0; i < WIDTH; i++) begin
            wrOff[i]  = pushCnt;
            wrAddr[i] = PTR_W'(wrPtr + wrOff[i]);
            rdAddr[i] = PTR_W'(rdPtr + (PTR_W+1)'(i));
            if (fusedUOps[i].valid) begin
                pushCnt = pushCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !mispredict) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (fusedUOps[i].valid) begin
                    mem[wrAddr[i]] <= fusedUOps[i];
                end
            end
        end
    end

    // Reads see only entries written at earlier edges.
    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            wrPtr <= '0;
            rdPtr <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                uops[i].valid <= 1'b0;
            end
        end else if (en) begin
            wrPtr <= wrPtr + pushCnt;
            rdPtr <= rdPtr + popCnt;
            for (int i = 0; i < WIDTH; i++) begin
                uops[i]       <= mem[rdAddr[i]];
                uops[i].valid <= (PTR_W+1)'(i) < popCnt;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fill <= (PTR_W+1)'(QUEUE_DEPTH));

endmodule

//--- DecodeFrontend.sv
`timescale 1ns/1ps

module DecodeFrontend #(
    parameter int WIDTH       = uopPkg::DEF_WIDTH,
    parameter int QUEUE_DEPTH = uopPkg::DEF_QUEUE_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic             mispredict,
    input  uopPkg::FetchSlot fetch[WIDTH],
    output uopPkg::DUOp      uops[WIDTH]
);

    import uopPkg::*;

    DUOp decUOps[WIDTH];
    DUOp fusedUOps[WIDTH];

    InstrDecoder #(
        .WIDTH(WIDTH)
    ) decoder (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .mispredict(mispredict),
        .fetch     (fetch),
        .decUOps   (decUOps)
    );

    UOpFuse #(
        .WIDTH(WIDTH)
    ) fuser (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .mispredict(mispredict),
        .decUOps   (decUOps),
        .fusedUOps (fusedUOps)
    );

    UOpQueue #(
        .WIDTH      (WIDTH),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .mispredict(mispredict),
        .fusedUOps (fusedUOps),
        .uops      (uops)
    );

endmodule

//--- DecodeFrontendTb.sv
`timescale 1ns/1ps

module DecodeFrontendTb;

    import uopPkg::*;

    localparam int W = 2;

    typedef struct packed {
        logic     en;
        logic     mp;
        FetchSlot s0;
        FetchSlot s1;
    } InRec;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  fu;
        logic [4:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs0;
        logic        immB;
        logic [31:0] imm;
    } ExpRec;

    logic     clk;
    logic     rst;
    logic     en;
    logic     mispredict;
    FetchSlot fetch[W];
    DUOp      uops[W];

    InRec   inQ[$];
    ExpRec  expQ[$];
    int     expIdx;
    int     errors;
    int     cycles;
    int     limit;
    integer seed;

    DecodeFrontend #(
        .WIDTH      (W),
        .QUEUE_DEPTH(8)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .mispredict(mispredict),
        .fetch     (fetch),
        .uops      (uops)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic readTrace();
        integer         fd;
        integer         code;
        integer         e;
        integer         m;
        integer         v0;
        integer         v1;
        integer         fu;
        integer         op;
        integer         rd;
        integer         rs0;
        integer         ib;
        logic [31:0]    p0;
        logic [31:0]    i0;
        logic [31:0]    p1;
        logic [31:0]    i1;
        logic [31:0]    imm;
        reg [8*8-1:0]   kind;
        reg [8*200-1:0] line;
        InRec           r;
        ExpRec          x;

        fd = $fopen("frontendTrace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file frontendTrace.txt");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "I") begin
                    code = $fscanf(fd, "%d %d %d %h %h %d %h %h",
                                   e, m, v0, p0, i0, v1, p1, i1);
                    if (code != 8) begin
                        errors++;
                        $display("An I record in the trace has missing fields");
                    end else begin
                        r = '{en: e[0], mp: m[0],
                              s0: '{valid: v0[0], pc: p0, instr: i0},
                              s1: '{valid: v1[0], pc: p1, instr: i1}};
                        inQ.push_back(r);
                    end
                end else if (kind == "E") begin
                    code = $fscanf(fd, "%h %d %d %d %d %d %h",
                                   p0, fu, op, rd, rs0, ib, imm);
                    if (code != 7) begin
                        errors++;
                        $display("An E record in the trace has missing fields");
                    end else begin
                        x = '{pc: p0, fu: fu[1:0], opcode: op[4:0], rd: rd[4:0],
                              rs0: rs0[4:0], immB: ib[0], imm: imm};
                        expQ.push_back(x);
                    end
                end else begin
                    // Comment line.
                    code = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveIdle(input logic enable);
        en            = enable;
        mispredict    = 1'b0;
        fetch[0]      = '0;
        fetch[1]      = '0;
    endtask

    // Consumer takes output groups only on enabled cycles.
    always @(posedge clk) begin
        if (!rst && en) begin
            for (int i = 0; i < W; i++) begin
                if (uops[i].valid) begin
                    if (expIdx >= expQ.size()) begin
                        errors++;
                        $display("Extra micro-op at pc %h came out after the expected list ended",
                                 uops[i].pc);
                    end else begin
                        checkValue(uops[i].pc, expQ[expIdx].pc, "pc");
                        checkValue(32'(uops[i].fu), 32'(expQ[expIdx].fu), "fu");
                        checkValue(32'(uops[i].opcode), 32'(expQ[expIdx].opcode), "opcode");
                        checkValue(32'(uops[i].rd), 32'(expQ[expIdx].rd), "rd");
                        checkValue(32'(uops[i].rs0), 32'(expQ[expIdx].rs0), "rs0");
                        checkValue(32'(uops[i].immB), 32'(expQ[expIdx].immB), "immB");
                        checkValue(uops[i].imm, expQ[expIdx].imm, "imm");
                        expIdx++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int n;

        clk        = 1'b0;
        rst        = 1'b1;
        seed       = 32'h9dc3;
        expIdx     = 0;
        errors     = 0;
        cycles     = 0;
        limit      = 1000000;
        driveIdle(1'b0);

        readTrace();
        limit = 8 * inQ.size() + 100;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        foreach (inQ[k]) begin
            en         = inQ[k].en;
            mispredict = inQ[k].mp;
            fetch[0]   = inQ[k].s0;
            fetch[1]   = inQ[k].s1;
            @(posedge clk);
            #2;
            // Random stall filler.
            n = $unsigned($random(seed)) % 3;
            if (n > 0) begin
                driveIdle(1'b0);
                repeat (n) @(posedge clk);
                #2;
            end
        end

        driveIdle(1'b1);
        for (int k = 0; k < 30 && expIdx < expQ.size(); k++) begin
            @(posedge clk);
            #2;
        end
        // A few more cycles to catch duplicates.
        repeat (4) @(posedge clk);
        #2;

        if (expIdx < expQ.size()) begin
            errors++;
            $display("%0d expected micro-ops never came out", expQ.size() - expIdx);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- frontendTrace.txt
# I en mispredict valid0 pc0 instr0 valid1 pc1 instr1
# E pc fu opcode rd rs0 immB imm   (fu and opcode as enum indexes)
# Plain decode.
I 1 0 1 00001000 002081B3 1 00001004 40118233
E 00001000 0 0 3 1 0 00000000
E 00001004 0 1 4 3 0 00000000
I 1 0 1 00001008 0020F2B3 1 0000100C 0020E333
E 00001008 0 2 5 1 0 00000000
E 0000100C 0 3 6 1 0 00000000
I 1 0 0 00000000 00000000 1 00001010 0020C3B3
E 00001010 0 4 7 1 0 00000000
I 0 0 0 00000000 00000000 0 00000000 00000000
I 1 0 1 00001014 01012403 1 00001018 00812A23
E 00001014 1 12 8 2 1 00000010
E 00001018 1 13 0 2 1 00000014
I 1 0 1 0000101C 00208463 1 00001020 010000EF
E 0000101C 2 14 0 1 0 00000008
E 00001020 2 16 1 0 0 00000010
# Fusion within a group, LUI then AUIPC.
I 1 0 1 00001024 123452B7 1 00001028 FFC28293
E 00001024 0 10 5 0 1 12344FFC
I 1 0 1 0000102C 00010317 1 00001030 80030313
E 0000102C 0 11 6 0 1 0000F800
# Illegal ECALL ahead of an ADD.
I 1 0 1 00001034 00000073 1 00001038 002081B3
E 00001034 3 0 0 0 0 00000000
E 00001038 0 0 3 1 0 00000000
# Fusion across groups with a stall in between.
I 1 0 1 0000103C 002081B3 1 00001040 ABCDE3B7
E 0000103C 0 0 3 1 0 00000000
E 00001040 0 10 7 0 1 ABCDE123
I 0 0 0 00000000 00000000 0 00000000 00000000
I 0 0 0 00000000 00000000 0 00000000 00000000
I 1 0 1 00001044 12338393 1 00001048 0020E333
E 00001048 0 3 6 1 0 00000000
# Pairs that must not fuse.
I 1 0 1 0000104C 000012B7 1 00001050 00130313
E 0000104C 0 10 5 0 1 00001000
E 00001050 0 0 6 6 1 00000001
I 1 0 1 00001054 000022B7 1 00001058 00130293
E 00001054 0 10 5 0 1 00002000
E 00001058 0 0 5 6 1 00000001
I 1 0 1 0000105C 000032B7 1 00001060 00128293
E 0000105C 0 10 5 0 1 00003001
I 1 0 1 00001064 00228293 1 00001068 FFFFFFFF
E 00001064 0 0 5 5 1 00000002
E 00001068 3 0 0 0 0 00000000
# Drain before the flush.
I 1 0 0 00000000 00000000 0 00000000 00000000
I 1 0 0 00000000 00000000 0 00000000 00000000
I 1 0 0 00000000 00000000 0 00000000 00000000
I 1 0 0 00000000 00000000 0 00000000 00000000
I 1 0 0 00000000 00000000 0 00000000 00000000
I 1 0 0 00000000 00000000 0 00000000 00000000
# These two groups are flushed and never come out.
I 1 0 1 00002000 002081B3 1 00002004 40118233
I 1 0 1 00002008 0020F2B3 1 0000200C 0020E333
I 1 1 0 00000000 00000000 0 00000000 00000000
# Fetched after the flush.
I 1 0 1 00003000 0020C3B3 1 00003004 01012403
E 00003000 0 4 7 1 0 00000000
E 00003004 1 12 8 2 1 00000010
I 1 0 1 00003008 010000EF 0 00000000 00000000
E 00003008 2 16 1 0 0 00000010

//--- filelist.f
uopPkg.sv
InstrDecoder.sv
UOpFuse.sv
UOpQueue.sv
DecodeFrontend.sv
DecodeFrontendTb.sv

//--- Bender.yml
package:
  name: decode_frontend

sources:
  - uopPkg.sv
  - InstrDecoder.sv
  - UOpFuse.sv
  - UOpQueue.sv
  - DecodeFrontend.sv
  - target: test
    files:
      - DecodeFrontendTb.sv
